// ==== source/hdc_pkg.sv ====
package hdc_pkg;

    // array geometry
    localparam int NUM_CORES  = 8;
    localparam int CORE_SEL_W = 3;

    // item words and accumulators share one width
    localparam int WORD_W     = 32;

    // item memory depth and symbol index width
    localparam int ITEM_DEPTH = 256;
    localparam int ADDR_W     = 8;

    // low word bits that give the rotate amount
    localparam int ROT_W      = 5;

    // memory read, timing register, accumulate
    localparam int PIPE_DEPTH = 3;

    // wide enough to hold PIPE_DEPTH itself
    localparam int PIPE_CNT_W = $clog2(PIPE_DEPTH + 1);

    // readout sequencing
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_DRAIN   = 2'd1,
        ST_CAPTURE = 2'd2,
        ST_SHIFT   = 2'd3
    } ctrl_state_t;

endpackage

// ==== source/hdc_item_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module hdc_item_mem
    import hdc_pkg::*;
(
    input  logic              clk,

    // load port
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [WORD_W-1:0] wdata,

    // registered lookup port
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [WORD_W-1:0] rdata
);

    logic [WORD_W-1:0] mem [ITEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read register holds until the next lookup
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // controller keeps loads out of cycles with a lookup
    a_no_rw_clash: assert property (@(posedge clk)
        !(we === 1'b1 && re === 1'b1));

endmodule

`default_nettype wire

// ==== source/hdc_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module hdc_core
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    // broadcast strobes from the controller
    input  logic              exec,
    input  logic              clr,

    // item memory load
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] mem_wdata,

    // this core's symbol
    input  logic [ADDR_W-1:0] sym_index,

    // readout chain
    input  logic              capture,
    input  logic              shift,
    input  logic [WORD_W-1:0] chain_in,
    output logic [WORD_W-1:0] chain_out
);

    logic                  exec_d1;
    logic                  exec_d2;
    logic                  clr_d1;
    logic                  clr_d2;
    logic [WORD_W-1:0]     item_word;
    logic [WORD_W-1:0]     tim_word;
    logic [2*WORD_W-1:0]   rot_dbl;
    logic [WORD_W-1:0]     rot_word;
    logic [WORD_W-1:0]     acc;

    // lookup happens at the edge ending the exec cycle
    hdc_item_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .re    (exec),
        .raddr (sym_index),
        .rdata (item_word)
    );

    // clr rides the same delay so clr then exec stays ordered
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_d1 <= 1'b0;
            exec_d2 <= 1'b0;
            clr_d1  <= 1'b0;
            clr_d2  <= 1'b0;
        end else begin
            exec_d1 <= exec;
            exec_d2 <= exec_d1;
            clr_d1  <= clr;
            clr_d2  <= clr_d1;
        end
    end

    // timing register breaks memory output from the rotator
    always_ff @(posedge clk) begin
        if (exec_d1) begin
            tim_word <= item_word;
        end
    end

    // rotate right by the word's own low bits
    always_comb begin
        rot_dbl  = {tim_word, tim_word} >> tim_word[ROT_W-1:0];
        rot_word = rot_dbl[WORD_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (clr_d2) begin
            acc <= '0;
        end else if (exec_d2) begin
            acc <= acc ^ rot_word;
        end
    end

    // capture has priority over shift
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chain_out <= '0;
        end else if (capture) begin
            chain_out <= acc;
        end else if (shift) begin
            chain_out <= chain_in;
        end
    end

    // capture is a lone cycle directly ahead of the shift run
    a_capture_then_shift: assert property (@(posedge clk) disable iff (!arst_n)
        capture |-> !shift ##1 shift);

endmodule

`default_nettype wire

// ==== source/hdc_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module hdc_ctrl
    import hdc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // strobes from outside
    input  logic                  sym_valid,
    input  logic                  clear,
    input  logic                  read_req,
    input  logic                  mem_we,
    input  logic [CORE_SEL_W-1:0] mem_core,

    // to the cores
    output logic                  exec,
    output logic                  clr,
    output logic                  capture,
    output logic                  shift,
    output logic [NUM_CORES-1:0]  mem_we_vec,

    // status
    output logic                  out_valid,
    output logic                  busy
);

    ctrl_state_t           state;
    logic [PIPE_CNT_W-1:0] drain_cnt;
    logic [CORE_SEL_W-1:0] shift_cnt;
    logic [PIPE_CNT_W-1:0] pend_cnt;
    logic                  idle;
    logic                  wr_ok;

    assign idle      = (state == ST_IDLE);
    assign busy      = !idle;

    // input strobes only count while idle
    assign exec      = sym_valid & idle;
    assign clr       = clear & idle;

    assign capture   = (state == ST_CAPTURE);
    assign shift     = (state == ST_SHIFT);
    assign out_valid = (state == ST_SHIFT);

    // no load while a lookup is in the pipeline
    assign wr_ok     = mem_we & idle & !exec & (pend_cnt == '0);

    always_comb begin
        mem_we_vec = '0;
        if (wr_ok) begin
            mem_we_vec[mem_core] = 1'b1;
        end
    end

    // cycles left until the last exec has reached the accumulators
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_cnt <= '0;
        end else if (exec) begin
            pend_cnt <= PIPE_CNT_W'(PIPE_DEPTH);
        end else if (pend_cnt != '0) begin
            pend_cnt <= pend_cnt - PIPE_CNT_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            drain_cnt <= '0;
            shift_cnt <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (read_req) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                ST_DRAIN: begin
                    if (drain_cnt == PIPE_CNT_W'(PIPE_DEPTH - 1)) begin
                        state <= ST_CAPTURE;
                    end else begin
                        drain_cnt <= drain_cnt + PIPE_CNT_W'(1);
                    end
                end
                ST_CAPTURE: begin
                    state     <= ST_SHIFT;
                    shift_cnt <= '0;
                end
                ST_SHIFT: begin
                    // one word per cycle with the top core first
                    if (shift_cnt == CORE_SEL_W'(NUM_CORES - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        shift_cnt <= shift_cnt + CORE_SEL_W'(1);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift run starts only after the full drain and one capture
    a_valid_after_drain: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_valid) |-> $past(capture) && $past(busy, PIPE_DEPTH + 1)
                             && !$past(busy, PIPE_DEPTH + 2));

    // busy ends right after a full shift run
    a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(out_valid) && $past(out_valid, NUM_CORES)
                        && $past(capture, NUM_CORES + 1));

endmodule

`default_nettype wire

// ==== source/hdc_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module hdc_array
    import hdc_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,

    // symbols with core k in slice k
    input  logic                        sym_valid,
    input  logic [NUM_CORES*ADDR_W-1:0] sym_index,
    input  logic                        clear,
    input  logic                        read_req,

    // item memory load
    input  logic                        mem_we,
    input  logic [CORE_SEL_W-1:0]       mem_core,
    input  logic [ADDR_W-1:0]           mem_addr,
    input  logic [WORD_W-1:0]           mem_wdata,

    // readout
    output logic [WORD_W-1:0]           acc_word,
    output logic                        out_valid,
    output logic                        busy
);

    logic                 exec;
    logic                 clr;
    logic                 capture;
    logic                 shift;
    logic [NUM_CORES-1:0] mem_we_vec;
    logic [WORD_W-1:0]    chain [NUM_CORES+1];

    hdc_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .sym_valid  (sym_valid),
        .clear      (clear),
        .read_req   (read_req),
        .mem_we     (mem_we),
        .mem_core   (mem_core),
        .exec       (exec),
        .clr        (clr),
        .capture    (capture),
        .shift      (shift),
        .mem_we_vec (mem_we_vec),
        .out_valid  (out_valid),
        .busy       (busy)
    );

    // bottom of the chain shifts in zeros
    assign chain[0] = '0;

    for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
        hdc_core u_core (
            .clk       (clk),
            .arst_n    (arst_n),
            .exec      (exec),
            .clr       (clr),
            .mem_we    (mem_we_vec[k]),
            .mem_addr  (mem_addr),
            .mem_wdata (mem_wdata),
            .sym_index (sym_index[k*ADDR_W +: ADDR_W]),
            .capture   (capture),
            .shift     (shift),
            .chain_in  (chain[k]),
            .chain_out (chain[k+1])
        );
    end

    // top of the chain is the last core
    assign acc_word = chain[NUM_CORES];

endmodule

`default_nettype wire

// ==== verif/hdc_array_tb.sv ====
`timescale 1ns/1ns

module hdc_array_tb
    import hdc_pkg::*;
;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 4;
    localparam int RUN_LONG      = 40;
    localparam int RUN_CLEAR     = 24;
    localparam int RUN_BUSY      = 16;
    localparam int N_READOUTS    = 5;
    localparam int BUSY_CYCLES   = PIPE_DEPTH + 1 + NUM_CORES;
    localparam int TOTAL_SYMBOLS = RUN_LONG + RUN_CLEAR + 2 * RUN_BUSY + 1;
    // load, symbols, readouts, plus slack for the gaps between phases
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CORES * ITEM_DEPTH + TOTAL_SYMBOLS
                                     + N_READOUTS * (BUSY_CYCLES + 4) + 100;

    logic                        clk;
    logic                        arst_n;
    logic                        sym_valid;
    logic [NUM_CORES*ADDR_W-1:0] sym_index;
    logic                        clear;
    logic                        read_req;
    logic                        mem_we;
    logic [CORE_SEL_W-1:0]       mem_core;
    logic [ADDR_W-1:0]           mem_addr;
    logic [WORD_W-1:0]           mem_wdata;
    logic [WORD_W-1:0]           acc_word;
    logic                        out_valid;
    logic                        busy;

    // reference model
    logic [WORD_W-1:0]     mem_model [NUM_CORES][ITEM_DEPTH];
    logic [WORD_W-1:0]     acc_model [NUM_CORES];
    logic [WORD_W-1:0]     exp_word;
    logic [15:0]           lfsr_state = 16'd90;
    logic [CORE_SEL_W-1:0] junk_core;
    logic [ADDR_W-1:0]     junk_addr;
    int                    rd_idx;
    int                    busy_cnt;
    int                    valid_total;

    hdc_array DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .sym_valid (sym_valid),
        .sym_index (sym_index),
        .clear     (clear),
        .read_req  (read_req),
        .mem_we    (mem_we),
        .mem_core  (mem_core),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .acc_word  (acc_word),
        .out_valid (out_valid),
        .busy      (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [WORD_W-1:0] take_bits(input int n);
        logic [WORD_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[WORD_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // bit i of the result comes from bit i+amt of the word
    function automatic logic [WORD_W-1:0] rotate_item(input logic [WORD_W-1:0] w);
        logic [WORD_W-1:0] r;
        int                amt;
        amt = int'(w[ROT_W-1:0]);
        for (int i = 0; i < WORD_W; i++) begin
            r[i] = w[(i + amt) % WORD_W];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [WORD_W-1:0] exp_v,
                                   input logic [WORD_W-1:0] act_v);
        $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // expected top word during the k-th shift cycle
    assign exp_word = (rd_idx < NUM_CORES) ? acc_model[NUM_CORES-1-rd_idx] : '0;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_idx      <= 0;
            busy_cnt    <= 0;
            valid_total <= 0;
        end else begin
            busy_cnt <= busy ? busy_cnt + 1 : 0;
            if (!busy) begin
                rd_idx <= 0;
            end else if (out_valid) begin
                rd_idx <= rd_idx + 1;
            end
            if (out_valid) begin
                valid_total <= valid_total + 1;
            end
        end
    end

    a_readout_word: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> acc_word == exp_word)
        else report_mismatch("acc_word", $sampled(exp_word), $sampled(acc_word));

    // chain has shifted zeros all the way through once idle
    a_idle_word: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |-> acc_word == '0)
        else report_mismatch("acc_word", '0, $sampled(acc_word));

    a_valid_count: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(out_valid) |-> rd_idx == NUM_CORES)
        else report_mismatch("out_valid_cycles", NUM_CORES, $sampled(rd_idx));

    a_busy_len: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> busy_cnt == BUSY_CYCLES)
        else report_mismatch("busy_cycles", BUSY_CYCLES, $sampled(busy_cnt));

    a_busy_bound: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> busy_cnt < BUSY_CYCLES)
        else report_mismatch("busy_cycles", BUSY_CYCLES, $sampled(busy_cnt) + 1);

    task automatic check_idle_outputs();
        a_rst_busy: assert (busy === 1'b0)
            else report_mismatch("busy", '0, WORD_W'(busy));
        a_rst_valid: assert (out_valid === 1'b0)
            else report_mismatch("out_valid", '0, WORD_W'(out_valid));
        a_rst_word: assert (acc_word === '0)
            else report_mismatch("acc_word", '0, acc_word);
    endtask

    task automatic load_memories();
        for (int k = 0; k < NUM_CORES; k++) begin
            for (int a = 0; a < ITEM_DEPTH; a++) begin
                @(negedge clk);
                mem_we    = 1'b1;
                mem_core  = CORE_SEL_W'(k);
                mem_addr  = ADDR_W'(a);
                mem_wdata = take_bits(WORD_W);
                mem_model[k][a] = mem_wdata;
            end
        end
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    // model is updated as soon as the symbol is accepted
    task automatic send_symbol(input logic [NUM_CORES*ADDR_W-1:0] idx_vec);
        logic [ADDR_W-1:0] idx;
        @(negedge clk);
        clear     = 1'b0;
        sym_valid = 1'b1;
        sym_index = idx_vec;
        for (int k = 0; k < NUM_CORES; k++) begin
            idx = idx_vec[k*ADDR_W +: ADDR_W];
            acc_model[k] = acc_model[k] ^ rotate_item(mem_model[k][idx]);
        end
    endtask

    task automatic send_random_symbols(input int n);
        logic [NUM_CORES*ADDR_W-1:0] vec;
        logic [WORD_W-1:0]           tmp;
        repeat (n) begin
            for (int k = 0; k < NUM_CORES; k++) begin
                tmp = take_bits(ADDR_W);
                vec[k*ADDR_W +: ADDR_W] = tmp[ADDR_W-1:0];
            end
            send_symbol(vec);
        end
        @(negedge clk);
        sym_valid = 1'b0;
    endtask

    task automatic do_clear();
        @(negedge clk);
        clear = 1'b1;
        for (int k = 0; k < NUM_CORES; k++) begin
            acc_model[k] = '0;
        end
    endtask

    // with junk set, every input strobe is hammered while busy
    task automatic run_readout(input bit junk);
        logic [WORD_W-1:0] tmp;
        @(negedge clk);
        read_req = 1'b1;
        @(negedge clk);
        read_req = 1'b0;
        if (junk) begin
            tmp       = take_bits(CORE_SEL_W);
            junk_core = tmp[CORE_SEL_W-1:0];
            tmp       = take_bits(ADDR_W);
            junk_addr = tmp[ADDR_W-1:0];
        end
        while (busy) begin
            if (junk) begin
                tmp       = take_bits(NUM_CORES * ADDR_W / 2);
                sym_index = {tmp, tmp};
                sym_valid = 1'b1;
                tmp       = take_bits(1);
                clear     = tmp[0];
                read_req  = 1'b1;
                mem_we    = 1'b1;
                mem_core  = junk_core;
                mem_addr  = junk_addr;
                mem_wdata = take_bits(WORD_W);
            end
            @(negedge clk);
        end
        sym_valid = 1'b0;
        clear     = 1'b0;
        read_req  = 1'b0;
        mem_we    = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        sym_valid = 1'b0;
        sym_index = '0;
        clear     = 1'b0;
        read_req  = 1'b0;
        mem_we    = 1'b0;
        mem_core  = '0;
        mem_addr  = '0;
        mem_wdata = '0;
        for (int k = 0; k < NUM_CORES; k++) begin
            acc_model[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        // empty readout before anything is loaded
        run_readout(1'b0);
        load_memories();

        send_random_symbols(RUN_LONG);
        run_readout(1'b0);

        do_clear();
        send_random_symbols(RUN_CLEAR);
        run_readout(1'b0);

        // junk inputs during readout are dropped and the hit address is read back next
        send_random_symbols(RUN_BUSY);
        run_readout(1'b1);
        send_symbol({NUM_CORES{junk_addr}});
        send_random_symbols(RUN_BUSY);
        run_readout(1'b0);

        repeat (2) @(negedge clk);
        if (valid_total == N_READOUTS * NUM_CORES) begin
            $display("TEST PASS");
            $finish;
        end else begin
            report_mismatch("readout_words", N_READOUTS * NUM_CORES, valid_total);
        end
    end

endmodule

// ==== flist.f ====
source/hdc_pkg.sv
source/hdc_item_mem.sv
source/hdc_core.sv
source/hdc_ctrl.sv
source/hdc_array.sv
verif/hdc_array_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module hdc_array_tb -Mdir "$OBJ" -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/Vhdc_array_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi

exit 0
